// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing --assert -Wno-fatal
TOP         = tb_uc_support
RTL_TOP     = uc_support_top
FILELIST    = verilog.f
OBJ_DIR     = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/apb_sram_slave.sv
// APB slave into shared SRAM
`timescale 1ns/1ps
`include "uc_defines.svh"

module apb_sram_slave (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  s_apb_psel,
   input  logic                  s_apb_penable,
   input  logic                  s_apb_pwrite,
   input  uc_apb_pkg::apb_addr_t s_apb_paddr,
   input  uc_apb_pkg::apb_data_t s_apb_pwdata,
   output uc_apb_pkg::apb_data_t s_apb_prdata,
   output logic                  s_apb_pready,
   sram_req_if.requester         sram
);

   logic setup_phase;

   assign setup_phase = s_apb_psel & ~s_apb_penable;

   // ----------------------------------------
   // SRAM request, one per transfer
   // ----------------------------------------
   assign sram.en    = setup_phase;
   assign sram.wr    = setup_phase & s_apb_pwrite;
   // APB bytes 15:2, top word bit unreachable from the host
   assign sram.addr  = {1'b0, s_apb_paddr[`UC_APB_ADDR_W-1:2]};
   assign sram.wdata = s_apb_pwdata;

   // ----------------------------------------
   // Access phase, never stretched
   // ----------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s_apb_pready <= 1'b0;
      end else begin
         s_apb_pready <= setup_phase;  // High for the access cycle only
      end
   end

   // SRAM word lands in the access cycle
   assign s_apb_prdata = sram.rdata;

endmodule

// File: rtl/core_apb_bridge.sv
// Core to APB master bridge
`timescale 1ns/1ps
`include "uc_defines.svh"

module core_apb_bridge (
   input  logic                   clk,
   input  logic                   arst_n,
   input  uc_apb_pkg::lane_id_t   ln_id,
   input  uc_apb_pkg::core_addr_t core_paddr,
   input  logic                   core_pen,
   input  logic                   core_pwr,
   input  uc_apb_pkg::apb_data_t  core_pwdata,
   output uc_apb_pkg::apb_data_t  core_prdata,
   output logic                   core_pbusy,
   output logic                   apb_psel,
   output logic                   apb_penable,
   output logic                   apb_pwrite,
   output uc_apb_pkg::apb_addr_t  apb_paddr,
   output uc_apb_pkg::apb_data_t  apb_pwdata,
   input  uc_apb_pkg::apb_data_t  apb_prdata,
   input  logic                   apb_pready
);

   uc_apb_pkg::bridge_state_t state;
   uc_apb_pkg::core_addr_t    lane_bits;
   uc_apb_pkg::core_addr_t    lane_addr;
   logic                      accept;
   logic                      done;

   // ----------------------------------------
   // Lane adjustment
   // ----------------------------------------
   // Firmware addresses lane 0 and the lane id is ORed in here.
   // PCS and PMA place the lane select at different bits.
   assign lane_bits = (core_paddr[`UC_CORE_ADDR_W-1 -: 2] == `UC_PCS_REGION)
                    ? (uc_apb_pkg::core_addr_t'(ln_id) << `UC_PCS_LANE_SHIFT)
                    : (uc_apb_pkg::core_addr_t'(ln_id) << `UC_PMA_LANE_SHIFT);
   assign lane_addr = core_paddr | lane_bits;

   assign accept = core_pen & (state == uc_apb_pkg::IDLE);
   assign done   = apb_pready & (state == uc_apb_pkg::ACCESS);

   // ----------------------------------------
   // APB phase FSM
   // ----------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= uc_apb_pkg::IDLE;
      end else begin
         case (state)
            uc_apb_pkg::IDLE:   if (core_pen) state <= uc_apb_pkg::SETUP;
            uc_apb_pkg::SETUP:  state <= uc_apb_pkg::ACCESS;
            uc_apb_pkg::ACCESS: if (apb_pready) state <= uc_apb_pkg::IDLE;
            default:            state <= uc_apb_pkg::IDLE;
         endcase
      end
   end

   assign apb_psel    = (state != uc_apb_pkg::IDLE);
   assign apb_penable = (state == uc_apb_pkg::ACCESS);
   assign core_pbusy  = (state != uc_apb_pkg::IDLE);  // Drops the cycle after pready

   // Request payload held for the whole transfer
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         apb_paddr   <= '0;
         apb_pwrite  <= 1'b0;
         apb_pwdata  <= '0;
         core_prdata <= '0;
      end else begin
         if (accept) begin
            apb_paddr  <= lane_addr;
            apb_pwrite <= core_pwr;
            apb_pwdata <= core_pwdata;
         end
         if (done) begin
            core_prdata <= apb_prdata;  // Held until the next completion
         end
      end
   end

endmodule

// File: rtl/sram_port_mux.sv
// SRAM port multiplexer
`timescale 1ns/1ps

module sram_port_mux (
   input  logic                   runstall,
   input  logic                   sram_init,
   sram_req_if.arbiter            fill,
   sram_req_if.arbiter            apb,
   input  uc_mem_pkg::sram_addr_t core_addr,
   input  logic                   core_en,
   input  logic                   core_wr,
   input  uc_mem_pkg::byte_mask_t core_byteen,
   input  uc_mem_pkg::sram_data_t core_wdata,
   output uc_mem_pkg::sram_data_t core_rdata,
   output uc_mem_pkg::sram_addr_t mem_addr,
   output logic                   mem_en_n,
   output logic                   mem_wr_n,
   output uc_mem_pkg::byte_mask_t mem_byte_mask_n,
   output uc_mem_pkg::sram_data_t mem_wdata,
   input  uc_mem_pkg::sram_data_t mem_rdata
);

   uc_mem_pkg::sram_addr_t req_addr;
   logic                   req_en;
   logic                   req_wr;
   uc_mem_pkg::sram_data_t req_wdata;

   // ----------------------------------------
   // Stalled side, fill engine over APB
   // ----------------------------------------
   assign req_addr  = sram_init ? fill.addr  : apb.addr;
   assign req_en    = sram_init ? fill.en    : apb.en;
   assign req_wr    = sram_init ? fill.wr    : apb.wr;
   assign req_wdata = sram_init ? fill.wdata : apb.wdata;

   // ----------------------------------------
   // Macro pins, active low controls
   // ----------------------------------------
   assign mem_addr        = runstall ? req_addr  : core_addr;
   assign mem_en_n        = runstall ? ~req_en   : ~core_en;
   assign mem_wr_n        = runstall ? ~req_wr   : ~core_wr;
   assign mem_byte_mask_n = runstall ? '0        : ~core_byteen;  // Full words when stalled
   assign mem_wdata       = runstall ? req_wdata : core_wdata;

   // Read return paths
   assign core_rdata = mem_rdata;
   assign apb.rdata  = runstall ? mem_rdata : '0;  // Host sees nothing while core runs
   assign fill.rdata = mem_rdata;

endmodule

// File: rtl/sram_req_if.sv
// SRAM requester link
`timescale 1ns/1ps

interface sram_req_if;

   uc_mem_pkg::sram_addr_t addr;
   logic                   en;     // Active high here, inverted at the macro
   logic                   wr;
   uc_mem_pkg::sram_data_t wdata;
   uc_mem_pkg::sram_data_t rdata;  // Valid one cycle after a read enable

   modport requester (
      output addr,
      output en,
      output wr,
      output wdata,
      input  rdata
   );

   modport arbiter (
      input  addr,
      input  en,
      input  wr,
      input  wdata,
      output rdata
   );

endinterface

// File: rtl/sram_zero_fill.sv
// SRAM zero fill engine
`timescale 1ns/1ps

module sram_zero_fill (
   input  logic          clk,
   input  logic          arst_n,
   input  logic          sram_init,
   output logic          sram_init_done,
   sram_req_if.requester sram
);

   uc_mem_pkg::sram_addr_t word_cnt;
   logic                   sweep;

   // Writing while requested and not yet finished
   assign sweep = sram_init & ~sram_init_done;

   assign sram.addr  = word_cnt;
   assign sram.en    = sweep;
   assign sram.wr    = sweep;
   assign sram.wdata = '0;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         word_cnt       <= '0;
         sram_init_done <= 1'b0;
      end else if (!sram_init) begin
         // Request withdrawn, rearm for the next sweep
         word_cnt       <= '0;
         sram_init_done <= 1'b0;
      end else if (!sram_init_done) begin
         word_cnt <= word_cnt + 1'b1;  // Wraps back to zero after last word
         if (word_cnt == '1) begin
            sram_init_done <= 1'b1;
         end
      end
   end

endmodule

// File: rtl/uc_apb_pkg.sv
// Peripheral bus types
`include "uc_defines.svh"

package uc_apb_pkg;

   typedef logic [`UC_APB_ADDR_W-1:0] apb_addr_t;
   typedef logic [`UC_DATA_W-1:0] apb_data_t;

   // Core side word address, before lane adjustment
   typedef logic [`UC_CORE_ADDR_W-1:0] core_addr_t;

   typedef logic [`UC_LANE_W-1:0] lane_id_t;

   // Core to APB bridge phases
   typedef enum logic [1:0] {
      IDLE,
      SETUP,
      ACCESS
   } bridge_state_t;

endpackage

// File: rtl/uc_defines.svh
// Microcontroller support widths
`ifndef UC_DEFINES_SVH
`define UC_DEFINES_SVH

// ----------------------------------------
// Shared SRAM
// ----------------------------------------
`define UC_SRAM_ADDR_W 15      // Word address, byte bits 16:2
`define UC_DATA_W 32
`define UC_BYTE_W 4            // Byte lanes per word

// ----------------------------------------
// Peripheral bus
// ----------------------------------------
`define UC_APB_ADDR_W 16
`define UC_CORE_ADDR_W 16      // Core word address, byte bits 17:2
`define UC_LANE_W 4

// Top two core address bits select PCS against PMA
`define UC_PCS_REGION 2'b11
`define UC_PCS_LANE_SHIFT 8
`define UC_PMA_LANE_SHIFT 9

`endif

// File: rtl/uc_mem_pkg.sv
// Shared SRAM types
`include "uc_defines.svh"

package uc_mem_pkg;

   // Word address into the macro
   typedef logic [`UC_SRAM_ADDR_W-1:0] sram_addr_t;

   // One SRAM word
   typedef logic [`UC_DATA_W-1:0] sram_data_t;

   // Per-byte mask, one bit per lane
   typedef logic [`UC_BYTE_W-1:0] byte_mask_t;

endpackage

// File: rtl/uc_support_top.sv
// Microcontroller support top
`timescale 1ns/1ps

module uc_support_top (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   runstall,     // Core stalled, SRAM open to host
   input  logic                   sram_init,
   output logic                   sram_init_done,
   // Host APB into the SRAM
   input  logic                   s_apb_psel,
   input  logic                   s_apb_penable,
   input  logic                   s_apb_pwrite,
   input  uc_apb_pkg::apb_addr_t  s_apb_paddr,
   input  uc_apb_pkg::apb_data_t  s_apb_pwdata,
   output uc_apb_pkg::apb_data_t  s_apb_prdata,
   output logic                   s_apb_pready,
   // APB master out to lane registers
   output logic                   apb_psel,
   output logic                   apb_penable,
   output logic                   apb_pwrite,
   output uc_apb_pkg::apb_addr_t  apb_paddr,
   output uc_apb_pkg::apb_data_t  apb_pwdata,
   input  uc_apb_pkg::apb_data_t  apb_prdata,
   input  logic                   apb_pready,
   input  uc_apb_pkg::lane_id_t   ln_id,        // Zero for the top controller
   // Core data RAM port
   input  uc_mem_pkg::sram_addr_t core_addr,
   input  logic                   core_en,
   input  logic                   core_wr,
   input  uc_mem_pkg::byte_mask_t core_byteen,
   input  uc_mem_pkg::sram_data_t core_wdata,
   output uc_mem_pkg::sram_data_t core_rdata,
   // Core peripheral load/store port
   input  uc_apb_pkg::core_addr_t core_paddr,
   input  logic                   core_pen,
   input  logic                   core_pwr,
   input  uc_apb_pkg::apb_data_t  core_pwdata,
   output uc_apb_pkg::apb_data_t  core_prdata,
   output logic                   core_pbusy,
   // SRAM macro
   output uc_mem_pkg::sram_addr_t mem_addr,
   output logic                   mem_en_n,
   output logic                   mem_wr_n,
   output uc_mem_pkg::byte_mask_t mem_byte_mask_n,
   output uc_mem_pkg::sram_data_t mem_wdata,
   input  uc_mem_pkg::sram_data_t mem_rdata
);

   sram_req_if apb_req ();
   sram_req_if fill_req ();

   apb_sram_slave u_apb_sram_slave (
      .clk           (clk),
      .arst_n        (arst_n),
      .s_apb_psel    (s_apb_psel),
      .s_apb_penable (s_apb_penable),
      .s_apb_pwrite  (s_apb_pwrite),
      .s_apb_paddr   (s_apb_paddr),
      .s_apb_pwdata  (s_apb_pwdata),
      .s_apb_prdata  (s_apb_prdata),
      .s_apb_pready  (s_apb_pready),
      .sram          (apb_req)
   );

   // Core must be stalled while the fill runs
   sram_zero_fill u_sram_zero_fill (
      .clk            (clk),
      .arst_n         (arst_n),
      .sram_init      (sram_init),
      .sram_init_done (sram_init_done),
      .sram           (fill_req)
   );

   sram_port_mux u_sram_port_mux (
      .runstall        (runstall),
      .sram_init       (sram_init),
      .fill            (fill_req),
      .apb             (apb_req),
      .core_addr       (core_addr),
      .core_en         (core_en),
      .core_wr         (core_wr),
      .core_byteen     (core_byteen),
      .core_wdata      (core_wdata),
      .core_rdata      (core_rdata),
      .mem_addr        (mem_addr),
      .mem_en_n        (mem_en_n),
      .mem_wr_n        (mem_wr_n),
      .mem_byte_mask_n (mem_byte_mask_n),
      .mem_wdata       (mem_wdata),
      .mem_rdata       (mem_rdata)
   );

   core_apb_bridge u_core_apb_bridge (
      .clk         (clk),
      .arst_n      (arst_n),
      .ln_id       (ln_id),
      .core_paddr  (core_paddr),
      .core_pen    (core_pen),
      .core_pwr    (core_pwr),
      .core_pwdata (core_pwdata),
      .core_prdata (core_prdata),
      .core_pbusy  (core_pbusy),
      .apb_psel    (apb_psel),
      .apb_penable (apb_penable),
      .apb_pwrite  (apb_pwrite),
      .apb_paddr   (apb_paddr),
      .apb_pwdata  (apb_pwdata),
      .apb_prdata  (apb_prdata),
      .apb_pready  (apb_pready)
   );

endmodule

// File: sim/tb_models.sv
// Testbench memory and bus models
`timescale 1ns/1ps
`include "uc_defines.svh"

// ----------------------------------------
// SRAM macro, active low controls
// ----------------------------------------
module tb_sram_model (
   input  logic                   clk,
   input  uc_mem_pkg::sram_addr_t addr,
   input  logic                   en_n,
   input  logic                   wr_n,
   input  uc_mem_pkg::byte_mask_t mask_n,
   input  uc_mem_pkg::sram_data_t wdata,
   output uc_mem_pkg::sram_data_t rdata
);

   uc_mem_pkg::sram_data_t mem [0:(1 << `UC_SRAM_ADDR_W)-1];

   initial begin
      // Start contents tied to the whole address
      for (int i = 0; i < (1 << `UC_SRAM_ADDR_W); i++) begin
         mem[i] = {~i[15:0], i[15:0]};
      end
      rdata = '0;
   end

   always @(posedge clk) begin
      if (!en_n && !wr_n) begin
         for (int b = 0; b < `UC_BYTE_W; b++) begin
            if (!mask_n[b]) mem[addr][8*b +: 8] <= wdata[8*b +: 8];
         end
      end else if (!en_n) begin
         rdata <= mem[addr];  // One cycle read latency
      end
   end

endmodule

// ----------------------------------------
// APB completer with random wait states
// ----------------------------------------
module tb_apb_completer (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  psel,
   input  logic                  penable,
   input  uc_apb_pkg::apb_addr_t paddr,
   output uc_apb_pkg::apb_data_t prdata,
   output logic                  pready
);

   logic [1:0] wait_left;

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wait_left <= '0;
      end else if (psel && !penable) begin
         wait_left <= 2'($urandom_range(3, 0));  // Stretch of the coming access
      end else if (psel && penable && wait_left != 2'd0) begin
         wait_left <= wait_left - 2'd1;
      end
   end

   assign pready = psel & penable & (wait_left == 2'd0);
   assign prdata = {paddr ^ 16'hc35a, ~paddr};  // Fixed mix of the address

endmodule

// File: sim/tb_uc_support.sv
// Support logic testbench
`timescale 1ns/1ps
`include "uc_defines.svh"

module tb_uc_support;

   localparam int SRAM_WORDS     = 1 << `UC_SRAM_ADDR_W;
   localparam int TIMEOUT_CYCLES = SRAM_WORDS + 7232;  // Full sweep plus bus tests
   localparam int N_XFER         = 16;

   logic                   clk = 1'b0;
   logic                   arst_n, runstall, sram_init, sram_init_done;
   logic                   s_apb_psel, s_apb_penable, s_apb_pwrite, s_apb_pready;
   uc_apb_pkg::apb_addr_t  s_apb_paddr;
   uc_apb_pkg::apb_data_t  s_apb_pwdata, s_apb_prdata;
   logic                   apb_psel, apb_penable, apb_pwrite, apb_pready;
   uc_apb_pkg::apb_addr_t  apb_paddr;
   uc_apb_pkg::apb_data_t  apb_pwdata, apb_prdata;
   uc_apb_pkg::lane_id_t   ln_id;
   uc_mem_pkg::sram_addr_t core_addr, mem_addr;
   logic                   core_en, core_wr, mem_en_n, mem_wr_n;
   uc_mem_pkg::byte_mask_t core_byteen, mem_byte_mask_n;
   uc_mem_pkg::sram_data_t core_wdata, core_rdata, mem_wdata, mem_rdata;
   uc_apb_pkg::core_addr_t core_paddr;
   logic                   core_pen, core_pwr, core_pbusy;
   uc_apb_pkg::apb_data_t  core_pwdata, core_prdata;
   int                     cycle_cnt = 0;

   always #50 clk = ~clk;

   uc_support_top dut_i (.*);

   tb_sram_model sram_i (
      .clk    (clk),
      .addr   (mem_addr),
      .en_n   (mem_en_n),
      .wr_n   (mem_wr_n),
      .mask_n (mem_byte_mask_n),
      .wdata  (mem_wdata),
      .rdata  (mem_rdata)
   );

   tb_apb_completer completer_i (
      .clk     (clk),
      .arst_n  (arst_n),
      .psel    (apb_psel),
      .penable (apb_penable),
      .paddr   (apb_paddr),
      .prdata  (apb_prdata),
      .pready  (apb_pready)
   );

   // ----------------------------------------
   // Checking and run limit
   // ----------------------------------------
   task automatic stop_on_error();
      $display("RESULT: FAIL");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         stop_on_error();
      end
   end

   // ----------------------------------------
   // Bus drivers
   // ----------------------------------------
   // Host transfer of two cycles with no wait states
   task automatic apb_transfer(input logic wr, input uc_apb_pkg::apb_addr_t addr,
                               input uc_apb_pkg::apb_data_t wdata,
                               output uc_apb_pkg::apb_data_t rdata);
      @(posedge clk);
      s_apb_psel    <= 1'b1;
      s_apb_penable <= 1'b0;
      s_apb_pwrite  <= wr;
      s_apb_paddr   <= addr;
      s_apb_pwdata  <= wdata;
      @(negedge clk);
      check_value("s_apb_pready", 32'(s_apb_pready), 32'd0);
      @(posedge clk);
      s_apb_penable <= 1'b1;
      @(negedge clk);
      check_value("s_apb_pready", 32'(s_apb_pready), 32'd1);
      rdata = s_apb_prdata;
      @(posedge clk);
      s_apb_psel    <= 1'b0;
      s_apb_penable <= 1'b0;
   endtask

   // One core data RAM access with its pins checked in the same cycle
   task automatic core_access(input logic wr, input uc_mem_pkg::sram_addr_t addr,
                              input uc_mem_pkg::byte_mask_t byteen,
                              input uc_mem_pkg::sram_data_t wdata);
      uc_mem_pkg::byte_mask_t exp_mask;
      exp_mask = ~byteen;
      @(posedge clk);
      core_en     <= 1'b1;
      core_wr     <= wr;
      core_addr   <= addr;
      core_byteen <= byteen;
      core_wdata  <= wdata;
      @(negedge clk);
      check_value("mem_en_n", 32'(mem_en_n), 32'd0);
      check_value("mem_wr_n", 32'(mem_wr_n), 32'(!wr));
      check_value("mem_addr", 32'(mem_addr), 32'(addr));
      check_value("mem_byte_mask_n", 32'(mem_byte_mask_n), 32'(exp_mask));
      check_value("mem_wdata", mem_wdata, wdata);
      @(posedge clk);
      core_en <= 1'b0;
      core_wr <= 1'b0;
   endtask

   task automatic bridge_transfer(input uc_apb_pkg::lane_id_t ln,
                                  input uc_apb_pkg::core_addr_t addr, input logic wr,
                                  input uc_apb_pkg::apb_data_t wdata);
      uc_apb_pkg::apb_addr_t exp_addr;
      int                    shift;
      shift = (addr[`UC_CORE_ADDR_W-1 -: 2] == `UC_PCS_REGION) ? `UC_PCS_LANE_SHIFT
                                                               : `UC_PMA_LANE_SHIFT;
      exp_addr = addr | 16'(32'(ln) << shift);
      @(posedge clk);
      ln_id       <= ln;
      core_paddr  <= addr;
      core_pen    <= 1'b1;
      core_pwr    <= wr;
      core_pwdata <= wdata;
      @(posedge clk);
      core_pen <= 1'b0;
      @(negedge clk);  // Setup cycle
      check_value("apb_psel", 32'(apb_psel), 32'd1);
      check_value("apb_penable", 32'(apb_penable), 32'd0);
      check_value("core_pbusy", 32'(core_pbusy), 32'd1);
      check_value("apb_paddr", 32'(apb_paddr), 32'(exp_addr));
      check_value("apb_pwrite", 32'(apb_pwrite), 32'(wr));
      check_value("apb_pwdata", apb_pwdata, wdata);
      do begin
         @(negedge clk);
         check_value("apb_penable", 32'(apb_penable), 32'd1);
         check_value("core_pbusy", 32'(core_pbusy), 32'd1);
      end while (!apb_pready);
      @(negedge clk);
      check_value("core_pbusy", 32'(core_pbusy), 32'd0);
      if (!wr) begin
         check_value("core_prdata", core_prdata, {exp_addr ^ 16'hc35a, ~exp_addr});
      end
   endtask

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial begin
      uc_apb_pkg::apb_addr_t  addrs [N_XFER];
      uc_apb_pkg::apb_data_t  data [N_XFER];
      uc_apb_pkg::apb_data_t  rd;
      uc_mem_pkg::byte_mask_t be;
      uc_mem_pkg::sram_data_t exp_word;
      int                     low_cycles;

      void'($urandom(32'h63cd));
      arst_n        <= 1'b0;
      runstall      <= 1'b1;
      sram_init     <= 1'b0;
      s_apb_psel    <= 1'b0;
      s_apb_penable <= 1'b0;
      s_apb_pwrite  <= 1'b0;
      s_apb_paddr   <= '0;
      s_apb_pwdata  <= '0;
      ln_id         <= '0;
      core_addr     <= '0;
      core_en       <= 1'b0;
      core_wr       <= 1'b0;
      core_byteen   <= '0;
      core_wdata    <= '0;
      core_paddr    <= '0;
      core_pen      <= 1'b0;
      core_pwr      <= 1'b0;
      core_pwdata   <= '0;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check_value("apb_psel", 32'(apb_psel), 32'd0);
      check_value("apb_penable", 32'(apb_penable), 32'd0);
      check_value("core_pbusy", 32'(core_pbusy), 32'd0);
      check_value("s_apb_pready", 32'(s_apb_pready), 32'd0);
      check_value("sram_init_done", 32'(sram_init_done), 32'd0);

      // Host writes and readback of distinct words while stalled
      for (int i = 0; i < N_XFER; i++) begin
         addrs[i] = {10'($urandom), 4'(i), 2'b00};
         data[i]  = $urandom;
         apb_transfer(1'b1, addrs[i], data[i], rd);
      end
      for (int i = 0; i < N_XFER; i++) begin
         apb_transfer(1'b0, addrs[i], '0, rd);
         check_value("s_apb_prdata", rd, data[i]);
      end

      // Zero fill sweeps one word per cycle
      @(posedge clk);
      sram_init <= 1'b1;
      low_cycles = 0;
      @(negedge clk);
      while (!sram_init_done) begin
         low_cycles++;
         @(negedge clk);
      end
      check_value("sram_init_done low cycles", low_cycles, SRAM_WORDS);
      @(posedge clk);
      sram_init <= 1'b0;
      @(negedge clk);
      check_value("sram_init_done", 32'(sram_init_done), 32'd1);
      @(negedge clk);
      check_value("sram_init_done", 32'(sram_init_done), 32'd0);
      for (int i = 0; i < N_XFER; i++) begin
         apb_transfer(1'b0, addrs[i], '0, rd);
         check_value("s_apb_prdata", rd, '0);
      end

      // Core owns the SRAM and host reads return zero
      @(posedge clk);
      runstall <= 1'b0;
      for (int i = 0; i < 4; i++) begin
         be      = 4'($urandom) | 4'b0001;
         data[i] = $urandom | 32'h1;
         core_access(1'b1, {1'b0, addrs[i][15:2]}, be, data[i]);
         apb_transfer(1'b0, addrs[i], '0, rd);
         check_value("s_apb_prdata", rd, '0);
         core_access(1'b0, {1'b0, addrs[i][15:2]}, be, '0);
         @(negedge clk);
         exp_word = '0;
         for (int b = 0; b < `UC_BYTE_W; b++) begin
            if (be[b]) exp_word[8*b +: 8] = data[i][8*b +: 8];
         end
         check_value("core_rdata", core_rdata, exp_word);
      end

      // Peripheral bridge with PCS on even and PMA on odd transfers
      for (int i = 0; i < 12; i++) begin
         bridge_transfer(4'($urandom),
                         {(i[0] ? 2'($urandom_range(2, 0)) : `UC_PCS_REGION), 14'($urandom)},
                         i[1], $urandom);
      end

      $display("RESULT: PASS");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+rtl
rtl/uc_mem_pkg.sv
rtl/uc_apb_pkg.sv
rtl/sram_req_if.sv
rtl/apb_sram_slave.sv
rtl/sram_zero_fill.sv
rtl/sram_port_mux.sv
rtl/core_apb_bridge.sv
rtl/uc_support_top.sv
sim/tb_models.sv
sim/tb_uc_support.sv
